// File: source/reg_pkg.sv
/*
 * Register operation package
 * Opcodes applied by the register bank and the operand width.
 */

package reg_pkg;

  parameter int operand_width = 24;
  parameter int op_width      = 4;

  // any code not listed here is illegal
  typedef enum logic [op_width-1:0] {
    OP_LOAD = 4'd0,   // register takes the operand
    OP_ADD  = 4'd1,   // register plus operand, wraps
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4
  } reg_op_t;

  // true for the opcodes the bank can execute
  function automatic logic op_is_legal(input reg_op_t op);
    logic legal;
    case (op)
      OP_LOAD, OP_ADD, OP_AND, OP_OR, OP_XOR: legal = 1'b1;
      default: legal = 1'b0;
    endcase
    return legal;
  endfunction

endpackage

// File: source/bus_pkg.sv
/*
 * Bus protocol package
 * Word width, the command and status word layouts and the state
 * encoding of the host bus sequencer.
 */

package bus_pkg;

  import reg_pkg::*;

  parameter int word_width  = 32;
  parameter int addr_width  = 4;
  parameter int count_width = 16;

  // one word as it appears on the parallel bus
  typedef logic [word_width-1:0] bus_word_t;

  // command word sent by the host, msb first
  typedef struct packed {
    reg_op_t                 opcode;
    logic [addr_width-1:0]   reg_addr;
    logic [operand_width-1:0] operand;
  } cmd_word_t;

  // status word returned after the data word
  typedef struct packed {
    logic                   error;
    logic [2:0]             spare_hi;
    reg_op_t                last_opcode;
    logic [addr_width-1:0]  last_addr;
    logic [3:0]             spare_lo;
    logic [count_width-1:0] count;      // wraps at 2^16
  } status_word_t;

  // sequencer states, grouped by transaction phase
  typedef enum logic [4:0] {
    // command phase
    S_RW0, S_RW1, S_RW2, S_RW3, S_RW4, S_RW5, S_RW6,
    // data word phase
    S_WWD0, S_WWD1, S_WWD2, S_WWD3, S_WWD4,
    // status word phase
    S_WWS0, S_WWS1, S_WWS2, S_WWS3, S_WWS4
  } bus_state_t;

endpackage

// File: source/bus_fsm.sv
/*
 * Bus sequencer
 * Moore machine that runs the command, data word and status word
 * phases of a host transaction and drives the handshake back.
 */

`timescale 1ns/100ps

module bus_fsm
  import bus_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic rw,
  input  logic subsystem_enable,
  input  logic handshake_1,
  output logic handshake_2,
  output logic read_word_from_bus,
  output logic execute_write,
  output logic write_data_word_to_bus,
  output logic write_status_word_to_bus
);

  bus_state_t state;
  bus_state_t next_state;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state <= S_RW0;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin : set_next_state
    // stay put unless a transition below fires
    next_state = state;
    unique case (state)
      // command word from host
      S_RW0:
        next_state = subsystem_enable ? S_RW1 : S_RW0;
      S_RW1:
        next_state = handshake_1 ? S_RW2 : S_RW1;
      S_RW2:
        next_state = rw ? S_RW3 : S_RW4;
      // write transactions pass through here to execute
      S_RW3:
        next_state = S_RW4;
      S_RW4:
        next_state = S_RW5;
      // wait for host to release handshake_1
      S_RW5:
        next_state = handshake_1 ? S_RW5 : S_RW6;
      S_RW6:
        next_state = S_WWD0;

      // data word to host
      S_WWD0:
        next_state = S_WWD1;
      S_WWD1:
        next_state = S_WWD2;
      S_WWD2:
        next_state = handshake_1 ? S_WWD3 : S_WWD2;
      S_WWD3:
        next_state = S_WWD4;
      S_WWD4:
        next_state = handshake_1 ? S_WWD4 : S_WWS0;

      // status word to host
      S_WWS0:
        next_state = S_WWS1;
      S_WWS1:
        next_state = S_WWS2;
      S_WWS2:
        next_state = handshake_1 ? S_WWS3 : S_WWS2;
      S_WWS3:
        next_state = S_WWS4;
      // transaction ends when handshake_1 falls here
      S_WWS4:
        next_state = handshake_1 ? S_WWS4 : S_RW0;
      default:
        next_state = S_RW0;
    endcase
  end

  // strobes decoded from state only
  assign read_word_from_bus = (state == S_RW2);
  assign execute_write      = (state == S_RW3);

  // word strobe leads handshake_2 by one cycle so bus_out is ready
  assign write_data_word_to_bus = (state == S_WWD0) ||
                                  (state == S_WWD1) ||
                                  (state == S_WWD2);

  assign write_status_word_to_bus = (state == S_WWS0) ||
                                    (state == S_WWS1) ||
                                    (state == S_WWS2);

  // acknowledge the command, then flag each reply word as valid
  assign handshake_2 = (state == S_RW3)  ||
                       (state == S_RW4)  ||
                       (state == S_WWD1) ||
                       (state == S_WWD2) ||
                       (state == S_WWS1) ||
                       (state == S_WWS2);

endmodule

// File: source/bus_word_port.sv
/*
 * Bus word port
 * Captures the command word from the host and registers the reply
 * words onto the outgoing bus together with the drive enable.
 */

`timescale 1ns/100ps

module bus_word_port
  import bus_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  bus_word_t    bus_in,
  input  logic         read_word_from_bus,
  input  logic         write_data_word_to_bus,
  input  logic         write_status_word_to_bus,
  input  bus_word_t    data_word,
  input  status_word_t status_word,
  output cmd_word_t    command,
  output bus_word_t    bus_out,
  output logic         bus_drive
);

  // command is held until the next read strobe
  always_ff @(posedge clk) begin
    if (read_word_from_bus) begin
      command <= cmd_word_t'(bus_in);
    end
  end

  // reply word, one cycle behind the strobe
  always_ff @(posedge clk) begin
    if (write_data_word_to_bus) begin
      bus_out <= data_word;
    end else if (write_status_word_to_bus) begin
      bus_out <= bus_word_t'(status_word);
    end
  end

  // enable follows either write strobe with the same delay
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      bus_drive <= 1'b0;
    end else begin
      bus_drive <= write_data_word_to_bus || write_status_word_to_bus;
    end
  end

endmodule

// File: source/register_bank.sv
/*
 * Register bank
 * Array of 32-bit registers addressed by the command word. Executes
 * the opcode on write transactions and builds the data and status
 * words returned to the host.
 */

`timescale 1ns/100ps

module register_bank
  import bus_pkg::*;
  import reg_pkg::*;
#(
  parameter int num_regs = 8
) (
  input  logic         clk,
  input  logic         reset,
  input  cmd_word_t    command,
  input  logic         execute_write,
  input  logic         read_word_from_bus,
  output bus_word_t    data_word,
  output status_word_t status_word
);

  bus_word_t regs [num_regs];

  logic                   cmd_valid;
  logic                   addr_bad;
  logic                   op_ok;
  bus_word_t              operand_ext;
  bus_word_t              cur_value;
  bus_word_t              op_result;
  logic                   error;
  reg_op_t                last_opcode;
  logic [addr_width-1:0]  last_addr;
  logic [count_width-1:0] trans_count;

  assign addr_bad    = (int'(command.reg_addr) >= num_regs);
  assign op_ok       = op_is_legal(command.opcode);
  assign operand_ext = {{(word_width - operand_width){1'b0}}, command.operand};

  // addressed register, zero when the address is out of range
  always_comb begin
    cur_value = '0;
    for (int i = 0; i < num_regs; i++) begin
      if (command.reg_addr == addr_width'(i)) begin
        cur_value = regs[i];
      end
    end
  end

  always_comb begin
    case (command.opcode)
      OP_LOAD: op_result = operand_ext;
      OP_ADD:  op_result = cur_value + operand_ext;
      OP_AND:  op_result = cur_value & operand_ext;
      OP_OR:   op_result = cur_value | operand_ext;
      OP_XOR:  op_result = cur_value ^ operand_ext;
      default: op_result = cur_value;
    endcase
  end

  // registers change only on a clean write
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (execute_write && !addr_bad && op_ok) begin
      for (int i = 0; i < num_regs; i++) begin
        if (command.reg_addr == addr_width'(i)) begin
          regs[i] <= op_result;
        end
      end
    end
  end

  // command register is loaded at the end of the read strobe,
  // so its fields are examined one cycle later
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      cmd_valid   <= 1'b0;
      error       <= 1'b0;
      last_opcode <= OP_LOAD;
      last_addr   <= '0;
      trans_count <= '0;
    end else begin
      cmd_valid <= read_word_from_bus;
      if (read_word_from_bus) begin
        trans_count <= trans_count + 1'b1;
      end
      if (cmd_valid) begin
        // opcode only matters on a write
        error       <= addr_bad || (execute_write && !op_ok);
        last_opcode <= command.opcode;
        last_addr   <= command.reg_addr;
      end
    end
  end

  assign data_word = cur_value;

  always_comb begin
    status_word             = '0;
    status_word.error       = error;
    status_word.last_opcode = last_opcode;
    status_word.last_addr   = last_addr;
    status_word.count       = trans_count;
  end

endmodule

// File: source/bus_subsystem.sv
/*
 * Bus subsystem top
 * Register-access slave on the 32-bit host bus. Joins the sequencer,
 * the word port and the register bank.
 */

`timescale 1ns/100ps

module bus_subsystem
  import bus_pkg::*;
#(
  parameter int num_regs = 8
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      rw,
  input  logic      subsystem_enable,
  input  logic      handshake_1,
  input  bus_word_t bus_in,
  output logic      handshake_2,
  output bus_word_t bus_out,
  output logic      bus_drive
);

  logic         read_word_from_bus;
  logic         execute_write;
  logic         write_data_word_to_bus;
  logic         write_status_word_to_bus;
  cmd_word_t    command;
  bus_word_t    data_word;
  status_word_t status_word;

  bus_fsm fsm_i (
    .clk                      (clk),
    .reset                    (reset),
    .rw                       (rw),
    .subsystem_enable         (subsystem_enable),
    .handshake_1              (handshake_1),
    .handshake_2              (handshake_2),
    .read_word_from_bus       (read_word_from_bus),
    .execute_write            (execute_write),
    .write_data_word_to_bus   (write_data_word_to_bus),
    .write_status_word_to_bus (write_status_word_to_bus)
  );

  bus_word_port port_i (
    .clk                      (clk),
    .reset                    (reset),
    .bus_in                   (bus_in),
    .read_word_from_bus       (read_word_from_bus),
    .write_data_word_to_bus   (write_data_word_to_bus),
    .write_status_word_to_bus (write_status_word_to_bus),
    .data_word                (data_word),
    .status_word              (status_word),
    .command                  (command),
    .bus_out                  (bus_out),
    .bus_drive                (bus_drive)
  );

  register_bank #(
    .num_regs (num_regs)
  ) bank_i (
    .clk                (clk),
    .reset              (reset),
    .command            (command),
    .execute_write      (execute_write),
    .read_word_from_bus (read_word_from_bus),
    .data_word          (data_word),
    .status_word        (status_word)
  );

endmodule

// File: tb/host_tasks.svh
/*
 * Host bus-cycle tasks
 * Runs one full transaction over the interlocked handshake, with a
 * random host delay in front of every handshake edge.
 */

// random value from 0 up to limit-1
function automatic int random_below(input int limit);
  return int'($unsigned($random(seed)) % $unsigned(limit));
endfunction

// host drives and samples 2 ns after the rising edge
task automatic next_cycle();
  @(posedge clk);
  #2;
endtask

task automatic host_pause();
  int cycles;
  cycles = random_below(max_delay + 1);
  repeat (cycles) next_cycle();
endtask

task automatic wait_handshake_2(input logic level);
  while (handshake_2 !== level) begin
    next_cycle();
  end
endtask

// subsystem has let go of the word when both are low
task automatic wait_word_released();
  while (handshake_2 !== 1'b0 || bus_drive !== 1'b0) begin
    next_cycle();
  end
endtask

task automatic take_reply_word(output bus_word_t word);
  wait_handshake_2(1'b1);
  word = bus_out;
  check_level(bus_drive, 1'b1, "bus_drive with handshake_2 high");
  host_pause();
  handshake_1 = 1'b1;
  wait_word_released();
  host_pause();
  handshake_1 = 1'b0;
endtask

task automatic run_transaction(input logic write, input cmd_word_t cmd);
  bus_word_t data_bits;
  bus_word_t status_bits;
  reply_t    got;
  host_pause();
  // request and command word go out together
  subsystem_enable = 1'b1;
  rw               = write;
  bus_in           = bus_word_t'(cmd);
  handshake_1      = 1'b1;
  wait_handshake_2(1'b1);
  host_pause();
  handshake_1 = 1'b0;
  wait_handshake_2(1'b0);
  take_reply_word(data_bits);
  take_reply_word(status_bits);
  subsystem_enable = 1'b0;
  // sequencer leaves S_WWS4 on the edge that sees handshake_1 low
  next_cycle();
  got.data   = data_bits;
  got.status = status_word_t'(status_bits);
  observed_q.push_back(got);
endtask

// File: tb/tb_bus_subsystem.sv
/*
 * Testbench for the bus subsystem
 * Runs host transactions over the interlocked handshake and checks the
 * returned data and status words against a reference model.
 */

`timescale 1ns/100ps

module tb_bus_subsystem
  import bus_pkg::*;
  import reg_pkg::*;
();

  localparam int num_regs         = 8;
  localparam int num_directed     = 29;
  localparam int num_random       = 40;
  localparam int num_transactions = num_directed + num_random;
  // 60 cycles of 20 ns per transaction plus room for reset
  localparam int watchdog_ns      = num_transactions * 60 * 20 + 2000;

  // one transaction's reply with the data word first
  typedef struct packed {
    bus_word_t    data;
    status_word_t status;
  } reply_t;

  logic      clk;
  logic      reset;
  logic      rw;
  logic      subsystem_enable;
  logic      handshake_1;
  bus_word_t bus_in;
  logic      handshake_2;
  bus_word_t bus_out;
  logic      bus_drive;

  integer seed            = 32'h765a_8e71;
  int     max_delay       = 0;
  int     data_errors     = 0;
  int     status_errors   = 0;
  int     protocol_errors = 0;
  int     checked         = 0;

  reply_t expected_q [$];
  reply_t observed_q [$];

  // model keeps all 16 addressable slots but writes only the first num_regs
  bus_word_t              model_regs [2**addr_width];
  logic [count_width-1:0] model_count;

  bus_subsystem #(
    .num_regs (num_regs)
  ) dut_i (
    .clk              (clk),
    .reset            (reset),
    .rw               (rw),
    .subsystem_enable (subsystem_enable),
    .handshake_1      (handshake_1),
    .bus_in           (bus_in),
    .handshake_2      (handshake_2),
    .bus_out          (bus_out),
    .bus_drive        (bus_drive)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_data(input bus_word_t got, input bus_word_t exp, input int index);
    if (got !== exp) begin
      data_errors++;
      $display("FAIL %0t: transaction %0d data word %h, expected %h",
               $time, index, got, exp);
    end
  endtask

  task automatic check_status(input status_word_t got, input status_word_t exp,
                              input int index);
    if (got !== exp) begin
      status_errors++;
      $display("FAIL %0t: transaction %0d status word %h, expected %h (count %0d/%0d)",
               $time, index, got, exp, got.count, exp.count);
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      protocol_errors++;
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  function automatic void model_reset();
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    model_count = '0;
  endfunction

  // expected reply of one transaction and the model state after it
  function automatic reply_t model_transaction(input logic write, input cmd_word_t cmd);
    reply_t              exp;
    bus_word_t           operand;
    bus_word_t           value;
    logic [op_width-1:0] code;
    logic                addr_bad;
    logic                op_bad;
    operand     = bus_word_t'(cmd.operand);
    code        = cmd.opcode;
    addr_bad    = int'(cmd.reg_addr) >= num_regs;
    op_bad      = code > op_width'(4);
    value       = model_regs[cmd.reg_addr];
    model_count = model_count + 1'b1;
    if (write && !addr_bad && !op_bad) begin
      case (cmd.opcode)
        OP_LOAD: value = operand;
        OP_ADD:  value = value + operand;
        OP_AND:  value = value & operand;
        OP_OR:   value = value | operand;
        OP_XOR:  value = value ^ operand;
        default: value = value;
      endcase
      model_regs[cmd.reg_addr] = value;
    end
    exp                    = '0;
    exp.data               = addr_bad ? '0 : model_regs[cmd.reg_addr];
    // illegal opcode only counts on a write
    exp.status.error       = addr_bad || (write && op_bad);
    exp.status.last_opcode = cmd.opcode;
    exp.status.last_addr   = cmd.reg_addr;
    exp.status.count       = model_count;
    return exp;
  endfunction

  function automatic cmd_word_t make_cmd(input logic [op_width-1:0] code, input int addr,
                                         input logic [operand_width-1:0] operand);
    cmd_word_t cmd;
    cmd.opcode   = reg_op_t'(code);
    cmd.reg_addr = addr_width'(addr);
    cmd.operand  = operand;
    return cmd;
  endfunction

  `include "host_tasks.svh"

  task automatic issue_transaction(input logic write, input cmd_word_t cmd);
    expected_q.push_back(model_transaction(write, cmd));
    run_transaction(write, cmd);
  endtask

  // pairs observed replies with expected ones between drive points
  always @(negedge clk) begin : compare_replies
    reply_t exp_r;
    reply_t got_r;
    if (expected_q.size() > 0 && observed_q.size() > 0) begin
      exp_r = expected_q.pop_front();
      got_r = observed_q.pop_front();
      checked++;
      check_data(got_r.data, exp_r.data, checked);
      check_status(got_r.status, exp_r.status, checked);
    end
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("timeout: host transactions did not finish within %0d ns", watchdog_ns);
    $display("Some tests failed");
    $finish;
  end

  initial begin : test_sequence
    reg_op_t                  ops      [5];
    logic [operand_width-1:0] operands [5];
    logic                     write_txn;
    logic [op_width-1:0]      code;
    int                       addr;
    reset            = 1'b0;
    rw               = 1'b0;
    subsystem_enable = 1'b0;
    handshake_1      = 1'b0;
    bus_in           = '0;
    model_reset();
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b1;
    next_cycle();
    check_level(handshake_2, 1'b0, "handshake_2 after reset");
    check_level(bus_drive, 1'b0, "bus_drive after reset");

    // every register reads back zero after reset
    for (int a = 0; a < num_regs; a++) begin
      issue_transaction(1'b0, make_cmd(OP_LOAD, a, 24'h0));
    end

    // each operation on one register followed by a read
    ops      = '{OP_LOAD, OP_ADD, OP_OR, OP_AND, OP_XOR};
    operands = '{24'hff_fff0, 24'h00_0020, 24'h80_0001, 24'h0f_0f0f, 24'hab_cdef};
    for (int i = 0; i < 5; i++) begin
      issue_transaction(1'b1, make_cmd(ops[i], 5, operands[i]));
      issue_transaction(1'b0, make_cmd(OP_LOAD, 5, 24'h0));
    end

    // bad address and illegal opcodes leave the registers alone
    // the bad address shares its low bits with register 5
    issue_transaction(1'b1, make_cmd(OP_LOAD, num_regs + 5, 24'h00_0bad));
    issue_transaction(1'b1, make_cmd(4'd7, 5, 24'h12_3456));
    issue_transaction(1'b0, make_cmd(OP_LOAD, 5, 24'h0));
    issue_transaction(1'b0, make_cmd(OP_OR, 15, 24'h0));
    issue_transaction(1'b1, make_cmd(4'hf, 15, 24'h00_0001));

    // back-to-back mix of writes and reads
    issue_transaction(1'b1, make_cmd(OP_LOAD, 0, 24'h5a_5a5a));
    issue_transaction(1'b0, make_cmd(OP_AND, 1, 24'h0));
    issue_transaction(1'b1, make_cmd(OP_XOR, 0, 24'hff_00ff));
    issue_transaction(1'b0, make_cmd(OP_XOR, 0, 24'h0));
    issue_transaction(1'b1, make_cmd(OP_ADD, num_regs - 1, 24'h7f_ffff));
    issue_transaction(1'b0, make_cmd(OP_ADD, num_regs - 1, 24'h0));

    // random traffic with host back-pressure in every wait
    max_delay = 3;
    for (int i = 0; i < num_random; i++) begin
      write_txn = random_below(2) == 1;
      code      = op_width'(random_below(8));
      addr      = random_below(num_regs + 2);
      issue_transaction(write_txn, make_cmd(code, addr, operand_width'($random(seed))));
    end

    repeat (3) next_cycle();
    if (checked != num_transactions || expected_q.size() != 0 || observed_q.size() != 0) begin
      protocol_errors++;
      $display("only %0d of %0d transactions were compared", checked, num_transactions);
    end
    $display("data errors %0d, status errors %0d, protocol errors %0d",
             data_errors, status_errors, protocol_errors);
    if (data_errors + status_errors + protocol_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+tb
source/reg_pkg.sv
source/bus_pkg.sv
source/bus_fsm.sv
source/bus_word_port.sv
source/register_bank.sv
source/bus_subsystem.sv
tb/tb_bus_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the bus subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_bus_subsystem \
  -f vlog.f \
  -o tb_bus_subsystem

output=$(./obj_dir/tb_bus_subsystem)
echo "$output"

if grep -qx "All tests passed" <<< "$output"; then
  exit 0
else
  exit 1
fi
